// ==== rtl/isa_pkg.sv ====
package isa_pkg;

  // one 32-bit alpha instruction word, read in two formats
  // opcode and ra sit in the same bits in both views
  typedef union packed {
    struct packed {
      logic [5:0]  opcode;    // bits 31:26
      logic [4:0]  ra;        // link / test register
      logic [20:0] disp;      // longword displacement
    } br;                     // branch format
    struct packed {
      logic [5:0]  opcode;
      logic [4:0]  ra;
      logic [4:0]  rb;        // holds the jump target at execute
      logic [1:0]  hint;      // jmp / jsr / ret / coroutine
      logic [13:0] hint_disp; // icache hint, not used here
    } jmp;                    // memory / jump format
  } alpha_inst_t;

  // unconditional direct branches
  localparam logic [5:0] op_br      = 6'h30;
  localparam logic [5:0] op_bsr     = 6'h34;

  // jmp, jsr, ret, jsr_coroutine share one opcode
  localparam logic [5:0] op_jsr_grp = 6'h1a;

  // conditional branches
  localparam logic [5:0] op_blbc    = 6'h38;
  localparam logic [5:0] op_beq     = 6'h39;
  localparam logic [5:0] op_blt     = 6'h3a;
  localparam logic [5:0] op_ble     = 6'h3b;
  localparam logic [5:0] op_blbs    = 6'h3c;
  localparam logic [5:0] op_bne     = 6'h3d;
  localparam logic [5:0] op_bge     = 6'h3e;
  localparam logic [5:0] op_bgt     = 6'h3f;

  // hint value of the jump group that marks a return
  localparam logic [1:0] jmp_hint_ret = 2'b10;

endpackage

// ==== rtl/bp_pkg.sv ====
package bp_pkg;

  // fetch width
  localparam int num_lanes = 2;

  // branch history table, indexed by pc[8:2]
  localparam int bht_idx_bits = 7;
  localparam int bht_entries  = 1 << bht_idx_bits;

  // indirect target buffer, index pc[6:2], tag pc[16:7]
  localparam int btb_idx_bits = 5;
  localparam int btb_tag_bits = 10;
  localparam int btb_entries  = 1 << btb_idx_bits;

  typedef logic [63:0] pc_t;

  // what the decoder found in one lane
  typedef enum logic [1:0] {
    kind_none     = 2'd0,
    kind_cond     = 2'd1, // counter decides
    kind_direct   = 2'd2, // br / bsr, always taken
    kind_indirect = 2'd3  // jump group, needs a btb hit
  } br_kind_t;

  // two-bit saturating counter, msb is the prediction
  typedef logic [1:0] ctr_t;

  localparam ctr_t ctr_min   = 2'b00; // strongly not taken
  localparam ctr_t ctr_reset = 2'b01; // weakly not taken
  localparam ctr_t ctr_max   = 2'b11; // strongly taken

endpackage

// ==== rtl/bp_resolve_if.sv ====
`timescale 1ns/1ns

// resolved branches coming back from execute, one level per cycle
interface bp_resolve_if;
  import bp_pkg::*;

  logic [num_lanes-1:0] res_valid;  // lane carries a report
  logic [num_lanes-1:0] res_cond;   // conditional branch
  logic [num_lanes-1:0] res_taken;  // actual outcome
  pc_t res_pc     [num_lanes];      // pc of the branch
  pc_t res_target [num_lanes];      // actual target when taken

  // both tables only listen
  modport table_side (
    input res_valid,
    input res_cond,
    input res_taken,
    input res_pc,
    input res_target
  );

endinterface

// ==== rtl/branch_decoder.sv ====
`timescale 1ns/1ns

module branch_decoder (
  input  isa_pkg::alpha_inst_t inst,
  input  bp_pkg::pc_t          pc,
  input  logic                 valid,
  output bp_pkg::br_kind_t     kind,
  output bp_pkg::pc_t          direct_target,
  output logic                 is_ret
);
  import isa_pkg::*;
  import bp_pkg::*;

  pc_t disp_bytes; // displacement scaled to bytes, sign extended

  // longword displacement -> byte offset
  assign disp_bytes    = {{41{inst.br.disp[20]}}, inst.br.disp, 2'b00};
  assign direct_target = pc + 64'd4 + disp_bytes; // relative to the updated pc

  always_comb begin
    kind   = kind_none;
    is_ret = 1'b0;
    if (valid) begin
      case (inst.br.opcode)
        op_blbc, op_beq, op_blt, op_ble,
        op_blbs, op_bne, op_bge, op_bgt: begin
          kind = kind_cond;
        end
        op_br, op_bsr: begin
          kind = kind_direct;
        end
        op_jsr_grp: begin
          kind   = kind_indirect;
          // same word, jump view for the hint bits
          is_ret = (inst.jmp.hint == jmp_hint_ret);
        end
        default: begin
          kind = kind_none; // alu, memory, fp ...
        end
      endcase
    end

    // a return is only ever part of the jump group
    assert (!is_ret || kind == kind_indirect)
      else $error("branch_decoder: is_ret without kind_indirect");
  end

endmodule

// ==== rtl/bht.sv ====
`timescale 1ns/1ns

module bht (
  input  logic                                clock,
  input  logic                                reset,
  input  bp_pkg::pc_t                         lookup_pc [bp_pkg::num_lanes],
  bp_resolve_if.table_side                    res,
  output logic [bp_pkg::num_lanes-1:0]        ctr_msb
);
  import bp_pkg::*;

  ctr_t table_q [bht_entries]; // registered counters
  ctr_t table_d [bht_entries]; // counters after this cycle's reports

  // one saturating step up or down
  function automatic ctr_t ctr_step(ctr_t c, logic up);
    ctr_t n;
    if (up) begin
      n = (c == ctr_max) ? c : c + 2'd1;
    end else begin
      n = (c == ctr_min) ? c : c - 2'd1;
    end
    return n;
  endfunction

  function automatic logic [bht_idx_bits-1:0] bht_idx(pc_t pc);
    return pc[bht_idx_bits+1:2]; // word aligned, skip bits 1:0
  endfunction

  // reports applied in lane order, lane 1 sees lane 0's step
  always_comb begin
    logic [bht_idx_bits-1:0] idx;
    table_d = table_q;
    for (int l = 0; l < num_lanes; l++) begin
      idx = bht_idx(res.res_pc[l]);
      if (res.res_valid[l] && res.res_cond[l]) begin
        table_d[idx] = ctr_step(table_d[idx], res.res_taken[l]);
      end
    end
  end

  // lookup bypasses the register, a report this cycle counts already
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      ctr_msb[l] = table_d[bht_idx(lookup_pc[l])][1];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      table_q <= '{default: ctr_reset};
    end else begin
      table_q <= table_d;
    end
  end

  // a lone not-taken report never raises its counter, no wrap below 0
  assert property (@(posedge clock) disable iff (reset)
    res.res_valid[0] && res.res_cond[0] && !res.res_taken[0] && !res.res_valid[1]
    |=> table_q[$past(bht_idx(res.res_pc[0]))] <= $past(table_q[bht_idx(res.res_pc[0])]))
    else $error("bht: not-taken report moved counter up");

  // a lone taken report never lowers its counter by the next cycle
  assert property (@(posedge clock) disable iff (reset)
    res.res_valid[0] && res.res_cond[0] && res.res_taken[0] && !res.res_valid[1]
    |=> table_q[$past(bht_idx(res.res_pc[0]))] >= $past(table_q[bht_idx(res.res_pc[0])]))
    else $error("bht: taken report moved counter down");

endmodule

// ==== rtl/btb.sv ====
`timescale 1ns/1ns

module btb (
  input  logic                         clock,
  input  logic                         reset,
  input  bp_pkg::pc_t                  lookup_pc [bp_pkg::num_lanes],
  bp_resolve_if.table_side             res,
  output logic [bp_pkg::num_lanes-1:0] hit,
  output bp_pkg::pc_t                  target [bp_pkg::num_lanes]
);
  import bp_pkg::*;

  logic [btb_entries-1:0]  valid_q, valid_d;       // entry holds a live target
  logic [btb_tag_bits-1:0] tag_q    [btb_entries];
  logic [btb_tag_bits-1:0] tag_d    [btb_entries];
  pc_t                     target_q [btb_entries]; // payload
  pc_t                     target_d [btb_entries];

  function automatic logic [btb_idx_bits-1:0] btb_idx(pc_t pc);
    return pc[btb_idx_bits+1:2]; // pc[6:2]
  endfunction

  function automatic logic [btb_tag_bits-1:0] btb_tag(pc_t pc);
    return pc[btb_idx_bits+2 +: btb_tag_bits]; // pc[16:7]
  endfunction

  // taken indirect jumps allocate, lane 1 written last so it wins
  always_comb begin
    logic [btb_idx_bits-1:0] idx;
    valid_d  = valid_q;
    tag_d    = tag_q;
    target_d = target_q;
    for (int l = 0; l < num_lanes; l++) begin
      idx = btb_idx(res.res_pc[l]);
      if (res.res_valid[l] && res.res_taken[l] && !res.res_cond[l]) begin
        valid_d[idx]  = 1'b1;
        tag_d[idx]    = btb_tag(res.res_pc[l]);
        target_d[idx] = res.res_target[l];
      end
    end
  end

  // lookups read next state, same-cycle report bypass
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      hit[l]    = valid_d[btb_idx(lookup_pc[l])] &&
                  (tag_d[btb_idx(lookup_pc[l])] == btb_tag(lookup_pc[l]));
      target[l] = target_d[btb_idx(lookup_pc[l])];
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= '0; // every entry empty
    end else begin
      valid_q <= valid_d;
    end
  end

  // tag and target payload
  always_ff @(posedge clock) begin
    tag_q    <= tag_d;
    target_q <= target_d;
  end

endmodule

// ==== rtl/fetch_redirect.sv ====
`timescale 1ns/1ns

module fetch_redirect (
  input  bp_pkg::br_kind_t             kind          [bp_pkg::num_lanes],
  input  bp_pkg::pc_t                  direct_target [bp_pkg::num_lanes],
  input  logic [bp_pkg::num_lanes-1:0] is_ret,
  input  logic [bp_pkg::num_lanes-1:0] ctr_msb,
  input  logic [bp_pkg::num_lanes-1:0] btb_hit,
  input  bp_pkg::pc_t                  btb_target    [bp_pkg::num_lanes],
  input  logic                         rollback,
  input  bp_pkg::pc_t                  rollback_target,
  output logic [bp_pkg::num_lanes-1:0] branch,
  output logic [bp_pkg::num_lanes-1:0] taken,
  output logic                         redirect,
  output bp_pkg::pc_t                  redirect_target
);
  import bp_pkg::*;

  logic [num_lanes-1:0] lane_branch;      // before rollback
  logic [num_lanes-1:0] lane_taken;       // before lane priority
  pc_t                  lane_target [num_lanes];

  // per-lane decision
  always_comb begin
    for (int l = 0; l < num_lanes; l++) begin
      lane_branch[l] = (kind[l] != kind_none);
      lane_target[l] = (kind[l] == kind_indirect) ? btb_target[l] : direct_target[l];
      case (kind[l])
        kind_direct:   lane_taken[l] = 1'b1;
        kind_cond:     lane_taken[l] = ctr_msb[l];             // counter msb
        kind_indirect: lane_taken[l] = btb_hit[l] && !is_ret[l]; // no ras, returns fall through
        default:       lane_taken[l] = 1'b0;
      endcase
    end
  end

  // oldest taken lane wins, rollback beats everything
  always_comb begin
    branch          = lane_branch;
    taken           = lane_taken;
    taken[1]        = lane_taken[1] && !lane_taken[0]; // younger lane is on the wrong path
    redirect        = |taken;
    redirect_target = '0;
    if (lane_taken[0]) begin
      redirect_target = lane_target[0];
    end else if (lane_taken[1]) begin
      redirect_target = lane_target[1];
    end
    if (rollback) begin
      branch          = '0;
      taken           = '0;
      redirect        = 1'b1;
      redirect_target = rollback_target;
    end

    // a taken lane must be a branch
    assert ((taken & ~branch) == '0)
      else $error("fetch_redirect: taken without branch");
  end

endmodule

// ==== rtl/bp_top.sv ====
`timescale 1ns/1ns

module bp_top (
  input  logic                         clock,
  input  logic                         reset,
  // fetch side
  input  bp_pkg::pc_t                  fetch_pc   [bp_pkg::num_lanes],
  input  logic [31:0]                  fetch_inst [bp_pkg::num_lanes],
  input  logic [bp_pkg::num_lanes-1:0] fetch_valid,
  // rollback from execute
  input  logic                         rollback,
  input  bp_pkg::pc_t                  rollback_target,
  // resolved branches from execute
  input  logic [bp_pkg::num_lanes-1:0] res_valid,
  input  logic [bp_pkg::num_lanes-1:0] res_cond,
  input  logic [bp_pkg::num_lanes-1:0] res_taken,
  input  bp_pkg::pc_t                  res_pc     [bp_pkg::num_lanes],
  input  bp_pkg::pc_t                  res_target [bp_pkg::num_lanes],
  // prediction back to fetch
  output logic [bp_pkg::num_lanes-1:0] branch,
  output logic [bp_pkg::num_lanes-1:0] taken,
  output logic                         redirect,
  output bp_pkg::pc_t                  redirect_target
);
  import bp_pkg::*;

  br_kind_t             kind          [num_lanes];
  pc_t                  direct_target [num_lanes];
  logic [num_lanes-1:0] is_ret;
  logic [num_lanes-1:0] ctr_msb;
  logic [num_lanes-1:0] btb_hit;
  pc_t                  btb_target    [num_lanes];

  // report bundle shared by both tables
  bp_resolve_if u_res_if ();

  assign u_res_if.res_valid  = res_valid;
  assign u_res_if.res_cond   = res_cond;
  assign u_res_if.res_taken  = res_taken;
  assign u_res_if.res_pc     = res_pc;
  assign u_res_if.res_target = res_target;

  // one decoder per fetch lane
  for (genvar l = 0; l < num_lanes; l++) begin : g_lane
    branch_decoder u_branch_decoder (
      .inst          (fetch_inst[l]),
      .pc            (fetch_pc[l]),
      .valid         (fetch_valid[l]),
      .kind          (kind[l]),
      .direct_target (direct_target[l]),
      .is_ret        (is_ret[l])
    );
  end

  bht u_bht (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (fetch_pc),
    .res       (u_res_if.table_side),
    .ctr_msb   (ctr_msb)
  );

  btb u_btb (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (fetch_pc),
    .res       (u_res_if.table_side),
    .hit       (btb_hit),
    .target    (btb_target)
  );

  fetch_redirect u_fetch_redirect (
    .kind            (kind),
    .direct_target   (direct_target),
    .is_ret          (is_ret),
    .ctr_msb         (ctr_msb),
    .btb_hit         (btb_hit),
    .btb_target      (btb_target),
    .rollback        (rollback),
    .rollback_target (rollback_target),
    .branch          (branch),
    .taken           (taken),
    .redirect        (redirect),
    .redirect_target (redirect_target)
  );

endmodule

// ==== sim/tb_bp_top.sv ====
`timescale 1ns/1ns

module tb_bp_top;
  import isa_pkg::*;
  import bp_pkg::*;

  localparam int reset_cycles = 10;
  localparam int p_reset_len = 4;       // directed idle / first lookups
  localparam int p_direct_len = 40;     // br, bsr and plain words
  localparam int p_counter_len = 24;    // one pc, counter walk
  localparam int p_indirect_len = 20;   // btb fill, alias, returns
  localparam int p_random_len = 300;    // everything mixed
  localparam int cycle_limit = reset_cycles + p_reset_len + p_direct_len + p_counter_len
                             + p_indirect_len + p_random_len + 100;

  logic clock;
  logic reset;
  pc_t fetch_pc [num_lanes];
  logic [31:0] fetch_inst [num_lanes];
  logic [num_lanes-1:0] fetch_valid, res_valid, res_cond, res_taken;
  logic rollback;
  pc_t rollback_target;
  pc_t res_pc [num_lanes];
  pc_t res_target [num_lanes];
  logic [num_lanes-1:0] branch, taken;
  logic redirect;
  pc_t redirect_target;

  // staged stimulus, copied onto the dut pins each cycle
  pc_t s_pc [num_lanes];
  logic [31:0] s_inst [num_lanes];
  logic [1:0] s_valid, s_rv, s_rc, s_rt;
  logic s_rb;
  pc_t s_rbt;
  pc_t s_rpc [num_lanes];
  pc_t s_rtgt [num_lanes];

  // reference tables, current and next state
  ctr_t m_ctr [bht_entries];
  ctr_t m_ctr_n [bht_entries];
  logic m_bv [btb_entries];
  logic m_bv_n [btb_entries];
  logic [btb_tag_bits-1:0] m_tag [btb_entries];
  logic [btb_tag_bits-1:0] m_tag_n [btb_entries];
  pc_t m_tgt [btb_entries];
  pc_t m_tgt_n [btb_entries];

  logic [1:0] e_branch, e_taken;
  logic e_redirect;
  pc_t e_target;

  logic [31:0] lfsr;
  int cycles;
  int err_bits, err_pc, err_bit;

  bp_top u_bp_top (
    .clock(clock), .reset(reset),
    .fetch_pc(fetch_pc), .fetch_inst(fetch_inst), .fetch_valid(fetch_valid),
    .rollback(rollback), .rollback_target(rollback_target),
    .res_valid(res_valid), .res_cond(res_cond), .res_taken(res_taken),
    .res_pc(res_pc), .res_target(res_target),
    .branch(branch), .taken(taken), .redirect(redirect), .redirect_target(redirect_target)
  );

  always #5 clock = ~clock;

  // run limit
  always @(posedge clock) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  // galois lfsr, one step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      r = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // small pool, bits 8 and 11 alias index and tag
  function automatic pc_t rand_pc();
    return 64'h0000_0001_2000_0000 + (take_bits(2) << 2)
         + take_bits(1) * 64'h800 + take_bits(1) * 64'h100;
  endfunction

  // weighted opcode pick, direct_only keeps cond and jumps out
  function automatic logic [31:0] rand_inst(input bit direct_only);
    logic [3:0] pick;
    logic [5:0] op;
    pick = 4'(take_bits(4));
    if (direct_only && pick >= 6) pick = (pick[0]) ? 4'd10 : 4'd2;
    if (pick < 6) begin
      case (take_bits(2))
        0: op = 6'h10; // integer alu
        1: op = 6'h11;
        2: op = 6'h28; // ldl
        default: op = 6'h2c;
      endcase
    end else if (pick < 10) begin
      op = 6'h38 + 6'(take_bits(3)); // any conditional branch
    end else if (pick < 12) begin
      op = take_bits(1) ? op_bsr : op_br;
    end else begin
      op = op_jsr_grp;
    end
    return {op, 5'(take_bits(5)), 21'(take_bits(21))};
  endfunction

  function automatic br_kind_t decode_kind(input logic [31:0] w);
    case (w[31:26])
      op_br, op_bsr: return kind_direct;
      op_jsr_grp: return kind_indirect;
      op_blbc, op_beq, op_blt, op_ble, op_blbs, op_bne, op_bge, op_bgt: return kind_cond;
      default: return kind_none;
    endcase
  endfunction

  task automatic check_bits(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cycles);
      err_bits++;
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cycles);
      err_pc++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s got %h expected %h at cycle %0d", name, got, exp, cycles);
      err_bit++;
    end
  endtask

  // reports first in lane order, then predict from the new state
  task automatic model_eval();
    int idx;
    longint disp;
    logic [1:0] lt;
    pc_t tgt [2];
    br_kind_t k;
    m_ctr_n = m_ctr;
    m_bv_n = m_bv;
    m_tag_n = m_tag;
    m_tgt_n = m_tgt;
    for (int l = 0; l < 2; l++) begin
      if (s_rv[l] && s_rc[l]) begin
        idx = s_rpc[l][8:2];
        if (s_rt[l] && m_ctr_n[idx] != 2'd3) m_ctr_n[idx] = m_ctr_n[idx] + 2'd1;
        else if (!s_rt[l] && m_ctr_n[idx] != 2'd0) m_ctr_n[idx] = m_ctr_n[idx] - 2'd1;
      end
      if (s_rv[l] && s_rt[l] && !s_rc[l]) begin
        idx = s_rpc[l][6:2];
        m_bv_n[idx] = 1'b1;
        m_tag_n[idx] = s_rpc[l][16:7];
        m_tgt_n[idx] = s_rtgt[l];
      end
    end
    for (int l = 0; l < 2; l++) begin
      k = s_valid[l] ? decode_kind(s_inst[l]) : kind_none;
      e_branch[l] = (k != kind_none);
      disp = longint'($signed(s_inst[l][20:0])); // signed longword count
      tgt[l] = s_pc[l] + 64'd4 + pc_t'(disp * 4);
      lt[l] = 1'b0;
      if (k == kind_direct) lt[l] = 1'b1;
      if (k == kind_cond) lt[l] = m_ctr_n[s_pc[l][8:2]][1];
      if (k == kind_indirect) begin
        idx = s_pc[l][6:2];
        tgt[l] = m_tgt_n[idx];
        lt[l] = m_bv_n[idx] && m_tag_n[idx] == s_pc[l][16:7]
             && s_inst[l][15:14] != jmp_hint_ret;
      end
    end
    e_taken = lt;
    if (lt[0]) e_taken[1] = 1'b0; // older lane wins
    e_redirect = |e_taken;
    e_target = lt[0] ? tgt[0] : (lt[1] ? tgt[1] : '0);
    if (s_rb) begin
      e_branch = '0;
      e_taken = '0;
      e_redirect = 1'b1;
      e_target = s_rbt;
    end
  endtask

  task automatic clear_stage();
    s_valid = '0;
    s_rv = '0;
    s_rc = '0;
    s_rt = '0;
    s_rb = 1'b0;
    s_rbt = '0;
    for (int l = 0; l < 2; l++) begin
      s_pc[l] = '0;
      s_inst[l] = '0;
      s_rpc[l] = '0;
      s_rtgt[l] = '0;
    end
  endtask

  // one cycle: commit, drive after the edge, check at the falling edge
  task automatic step();
    @(posedge clock);
    m_ctr = m_ctr_n;
    m_bv = m_bv_n;
    m_tag = m_tag_n;
    m_tgt = m_tgt_n;
    #1;
    fetch_pc = s_pc;
    fetch_inst = s_inst;
    fetch_valid = s_valid;
    rollback = s_rb;
    rollback_target = s_rbt;
    res_valid = s_rv;
    res_cond = s_rc;
    res_taken = s_rt;
    res_pc = s_rpc;
    res_target = s_rtgt;
    model_eval();
    @(negedge clock);
    check_bits("branch", branch, e_branch);
    check_bits("taken", taken, e_taken);
    check_bit("redirect", redirect, e_redirect);
    if (e_redirect) check_pc("redirect_target", redirect_target, e_target);
  endtask

  initial begin
    pc_t p;
    pc_t q;
    clock = 1'b0;
    reset = 1'b1;
    lfsr = 32'h99a9;
    cycles = 0;
    err_bits = 0;
    err_pc = 0;
    err_bit = 0;
    fetch_valid = '0;
    rollback = 1'b0;
    rollback_target = '0;
    res_valid = '0;
    res_cond = '0;
    res_taken = '0;
    for (int l = 0; l < 2; l++) begin
      fetch_pc[l] = '0;
      fetch_inst[l] = '0;
      res_pc[l] = '0;
      res_target[l] = '0;
    end
    for (int i = 0; i < bht_entries; i++) m_ctr_n[i] = ctr_reset;
    for (int i = 0; i < btb_entries; i++) begin
      m_bv_n[i] = 1'b0;
      m_tag_n[i] = '0;
      m_tgt_n[i] = '0;
    end
    clear_stage();
    repeat (reset_cycles) @(posedge clock);
    #1 reset = 1'b0;

    // reset state, cond at weak not taken, jump misses
    p = 64'h0000_0001_2000_0040;
    step();
    s_valid = 2'b01;
    s_pc[0] = p;
    s_inst[0] = {op_beq, 5'd1, 21'd8};
    step();
    s_valid = 2'b11;
    s_pc[1] = p + 4;
    s_inst[1] = {op_jsr_grp, 5'd26, 5'd3, 2'b00, 14'd0};
    step();
    clear_stage();
    step();

    // direct branches and plain words
    for (int i = 0; i < p_direct_len; i++) begin
      s_valid = 2'(take_bits(2));
      for (int l = 0; l < 2; l++) begin
        s_pc[l] = rand_pc();
        s_inst[l] = rand_inst(1'b1);
      end
      step();
    end

    // counter walk at one pc, reports in the same cycle as the fetch
    clear_stage();
    s_valid = 2'b01;
    s_pc[0] = p;
    s_inst[0] = {op_bne, 5'd2, 21'h1ffff0};
    for (int i = 0; i < p_counter_len; i++) begin
      s_rc = 2'b11;
      s_rpc[0] = p;
      s_rpc[1] = p;
      s_rv = (i < 14) ? 2'b01 : 2'b11;
      s_rt = (i < 6) ? 2'b11 : (i < 14) ? 2'b00 : (i < 18) ? 2'b11 : {1'b0, i[0]};
      step();
    end

    // indirect jumps, alias pc q shares index but not tag
    clear_stage();
    p = 64'h0000_0001_2000_0044;
    q = p + 64'h800;
    for (int i = 0; i < p_indirect_len; i++) begin
      s_valid = 2'b11;
      s_rv = '0;
      s_pc[0] = (i >= 3 && i < 7) ? q : p;
      s_pc[1] = p;
      s_inst[0] = {op_jsr_grp, 5'd26, 5'd4, (i >= 7 && i < 10) ? jmp_hint_ret : 2'b00, 14'd0};
      s_inst[1] = {op_jsr_grp, 5'd26, 5'd4, 2'(take_bits(2)), 14'd0};
      if (i == 2 || i == 10) begin
        s_rv = (i == 2) ? 2'b01 : 2'b11;
        s_rt = 2'b11;
        s_rc = 2'b00;
        s_rpc[0] = (i == 2) ? p : q;
        s_rpc[1] = p;
        s_rtgt[0] = 64'h0000_0002_0000_1000 + i;
        s_rtgt[1] = 64'h0000_0002_0000_2000;
      end
      if (i >= 11) begin
        s_pc[0] = take_bits(1) ? q : p;
        s_inst[0][15:14] = 2'(take_bits(2));
      end
      step();
    end

    // everything random, rollback now and then
    for (int i = 0; i < p_random_len; i++) begin
      s_valid = 2'(take_bits(2));
      s_rv = 2'(take_bits(2));
      s_rc = 2'(take_bits(2));
      s_rt = 2'(take_bits(2));
      s_rb = (take_bits(4) == 0);
      s_rbt = {32'(take_bits(32)), 32'(take_bits(32))};
      for (int l = 0; l < 2; l++) begin
        s_pc[l] = rand_pc();
        s_inst[l] = rand_inst(1'b0);
        s_rpc[l] = rand_pc();
        s_rtgt[l] = {32'(take_bits(32)), 30'(take_bits(30)), 2'b00};
      end
      step();
    end

    $display("errors: branch/taken %0d, redirect_target %0d, redirect %0d",
             err_bits, err_pc, err_bit);
    if (err_bits + err_pc + err_bit == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== bp.f ====
rtl/isa_pkg.sv
rtl/bp_pkg.sv
rtl/bp_resolve_if.sv
rtl/branch_decoder.sv
rtl/bht.sv
rtl/btb.sv
rtl/fetch_redirect.sv
rtl/bp_top.sv
sim/tb_bp_top.sv

// ==== Makefile ====
# Verilator build of the branch predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_bp_top
FILELIST  ?= bp.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
